// File: flist.f
+incdir+.
game2048_pkg.sv
line_lane_if.sv
game2048_axil_regs.sv
move_dispatch.sv
line_merge.sv
board_update.sv
game2048_core.sv
tb_clock_gen.sv
tb_game2048.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module tb_game2048 -o sim_game2048 > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_game2048 > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulator exited with status $sim_status"
	exit 1
fi

if grep -q "Simulation FAILED" "$SIM_LOG"; then
	exit 1
fi
exit 0

// File: tb_game2048.sv
`default_nettype none

module tb_game2048;

	// Roughly 1550 register transactions across all tests
	localparam int TXN_COUNT = 1600;
	localparam int CYCLE_LIMIT = 16 * TXN_COUNT + 400;

	localparam logic [4:0] ADDR_MOVE     = 5'h00;
	localparam logic [4:0] ADDR_STATUS   = 5'h04;
	localparam logic [4:0] ADDR_SCORE    = 5'h08;
	localparam logic [4:0] ADDR_SEED     = 5'h0C;
	localparam logic [4:0] ADDR_BOARD_LO = 5'h10;
	localparam logic [4:0] ADDR_BOARD_HI = 5'h14;

	logic        clk;
	logic        rst_n;
	logic [4:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [4:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;

	// Reference state
	logic [63:0] m_board;
	logic [31:0] m_score;
	logic [15:0] m_lfsr;
	bit          m_moved;
	bit          m_over;

	logic [31:0] got_q [$];
	logic [31:0] exp_q [$];
	string       tag_q [$];
	int          checks = 0;
	int          errors = 0;
	int          cycles = 0;

	tb_clock_gen #(.PERIOD(40)) u_clk (.clk(clk));

	game2048_core DUT (
		.clk_sys (clk),
		.rst_n   (rst_n),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready)
	);

	function automatic int tile_at(logic [63:0] b, int r, int c);
		return int'(b[4 * (4 * r + c) +: 4]);
	endfunction

	// Grid cell of element k in line i for a move direction
	function automatic int cell_of(int d, int i, int k);
		int row;
		int col;
		case (d)
			0: begin
				row = i;
				col = k;
			end
			1: begin
				row = i;
				col = 3 - k;
			end
			2: begin
				row = k;
				col = i;
			end
			default: begin
				row = 3 - k;
				col = i;
			end
		endcase
		return row * 4 + col;
	endfunction

	function automatic bit no_moves_left(logic [63:0] b);
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++) begin
				if (tile_at(b, r, c) == 0)
					return 1'b0;
				if (c < 3 && tile_at(b, r, c) == tile_at(b, r, c + 1))
					return 1'b0;
				if (r < 3 && tile_at(b, r, c) == tile_at(b, r + 1, c))
					return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	function automatic void model_move(inout logic [63:0] b, inout logic [31:0] sc,
			inout logic [15:0] g, output bit moved, output bit over, input int d);
		int src [4];
		int dst [4];
		int vals [$];
		int n;
		int j;
		int pos;
		moved = 1'b0;
		for (int i = 0; i < 4; i++) begin
			vals.delete();
			for (int k = 0; k < 4; k++) begin
				src[k] = int'(b[4 * cell_of(d, i, k) +: 4]);
				dst[k] = 0;
				if (src[k] != 0)
					vals.push_back(src[k]);
			end
			n = 0;
			j = 0;
			while (j < vals.size()) begin
				if (j + 1 < vals.size() && vals[j] == vals[j + 1] && vals[j] < 15) begin
					dst[n] = vals[j] + 1;
					sc = sc + (32'd1 << dst[n]);
					j = j + 2;
				end else begin
					dst[n] = vals[j];
					j = j + 1;
				end
				n++;
			end
			for (int k = 0; k < 4; k++) begin
				if (dst[k] != src[k])
					moved = 1'b1;
				b[4 * cell_of(d, i, k) +: 4] = 4'(dst[k]);
			end
		end
		if (moved) begin
			g = (g >> 1) ^ (g[0] ? 16'hB400 : 16'h0000);
			for (int s = 0; s < 16; s++) begin
				pos = (int'(g[3:0]) + s) % 16;
				if (b[4 * pos +: 4] == 4'd0) begin
					b[4 * pos +: 4] = g[4] ? 4'd2 : 4'd1;
					break;
				end
			end
		end
		over = no_moves_left(b);
	endfunction

	// Rows given as hex, column 0 in the top nibble
	function automatic logic [63:0] rows_to_board(logic [15:0] r0, logic [15:0] r1,
			logic [15:0] r2, logic [15:0] r3);
		logic [15:0] rows [4];
		logic [63:0] b;
		rows[0] = r0;
		rows[1] = r1;
		rows[2] = r2;
		rows[3] = r3;
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++)
				b[4 * (4 * r + c) +: 4] = rows[r][15 - 4 * c -: 4];
		end
		return b;
	endfunction

	// About half the cells empty, the rest small tiles
	function automatic logic [63:0] random_board();
		logic [63:0] b;
		int r;
		for (int i = 0; i < 16; i++) begin
			r = int'($urandom % 8);
			b[4 * i +: 4] = r < 4 ? 4'd0 : 4'(r - 3);
		end
		return b;
	endfunction

	function automatic void expect_word(string tag, logic [31:0] got, logic [31:0] exp);
		tag_q.push_back(tag);
		got_q.push_back(got);
		exp_q.push_back(exp);
	endfunction

	task automatic write_reg(input logic [4:0] addr, input logic [31:0] data, output int stall);
		stall = 0;
		awaddr  <= addr;
		awvalid <= 1'b1;
		wdata   <= data;
		wstrb   <= 4'hF;
		wvalid  <= 1'b1;
		@(negedge clk);
		while (!awready) begin
			stall++;
			@(negedge clk);
		end
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		@(negedge clk);
		while (!bvalid)
			@(negedge clk);
		expect_word("BRESP", {30'd0, bresp}, 32'd0);
		@(posedge clk);
	endtask

	task automatic read_reg(input logic [4:0] addr, output logic [31:0] data);
		araddr  <= addr;
		arvalid <= 1'b1;
		@(negedge clk);
		while (!arready)
			@(negedge clk);
		@(posedge clk);
		arvalid <= 1'b0;
		@(negedge clk);
		while (!rvalid)
			@(negedge clk);
		data = rdata;
		expect_word("RRESP", {30'd0, rresp}, 32'd0);
		@(posedge clk);
	endtask

	task automatic load_board(input logic [63:0] b);
		int stall;
		write_reg(ADDR_BOARD_LO, b[31:0], stall);
		write_reg(ADDR_BOARD_HI, b[63:32], stall);
		m_board = b;
		m_score = '0;
		m_over = no_moves_left(b);
	endtask

	task automatic set_seed(input logic [15:0] s);
		int stall;
		write_reg(ADDR_SEED, {16'd0, s}, stall);
		m_lfsr = s;
	endtask

	task automatic start_move(input logic [1:0] d, output int stall);
		write_reg(ADDR_MOVE, {30'd0, d}, stall);
		model_move(m_board, m_score, m_lfsr, m_moved, m_over, int'(d));
	endtask

	task automatic wait_idle();
		logic [31:0] st;
		read_reg(ADDR_STATUS, st);
		while (st[0])
			read_reg(ADDR_STATUS, st);
	endtask

	task automatic play_move(input logic [1:0] d);
		int stall;
		start_move(d, stall);
		wait_idle();
	endtask

	task automatic check_state(input string what);
		logic [31:0] v;
		read_reg(ADDR_STATUS, v);
		expect_word({what, " STATUS"}, v, {29'd0, m_moved, m_over, 1'b0});
		read_reg(ADDR_SCORE, v);
		expect_word({what, " SCORE"}, v, m_score);
		read_reg(ADDR_BOARD_LO, v);
		expect_word({what, " BOARD_LO"}, v, m_board[31:0]);
		read_reg(ADDR_BOARD_HI, v);
		expect_word({what, " BOARD_HI"}, v, m_board[63:32]);
	endtask

	always @(posedge clk) begin : compare
		logic [31:0] got;
		logic [31:0] exp;
		string tag;
		while (got_q.size() > 0) begin
			got = got_q.pop_front();
			exp = exp_q.pop_front();
			tag = tag_q.pop_front();
			checks++;
			assert (got == exp) else begin
				errors++;
				$display("** Error at time %0t: %s is %h, expected %h", $time, tag, got, exp);
			end
		end
	end

	always @(posedge clk) begin : watchdog
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin : stimulus
		logic [31:0] v;
		logic [63:0] boards [2];
		int stall;
		rst_n   = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		m_board = '0;
		m_score = '0;
		m_lfsr  = 16'h0001;
		m_moved = 1'b0;
		m_over  = 1'b0;
		void'($urandom(32'hd5db_8561));
		repeat (16) @(posedge clk);
		rst_n  <= 1'b1;
		bready <= 1'b1;
		rready <= 1'b1;
		@(posedge clk);

		read_reg(ADDR_STATUS, v);
		expect_word("reset STATUS", v, 32'd0);
		read_reg(ADDR_SCORE, v);
		expect_word("reset SCORE", v, 32'd0);
		read_reg(ADDR_BOARD_LO, v);
		expect_word("reset BOARD_LO", v, 32'd0);
		read_reg(ADDR_BOARD_HI, v);
		expect_word("reset BOARD_HI", v, 32'd0);

		// Second board has a 15 pair that must not merge
		boards[0] = rows_to_board(16'h1122, 16'h1011, 16'h0001, 16'h2020);
		boards[1] = rows_to_board(16'hFF11, 16'h3333, 16'h0222, 16'h4004);
		for (int b = 0; b < 2; b++) begin
			for (int d = 0; d < 4; d++) begin
				load_board(boards[b]);
				set_seed(16'hACE1 + 16'(b * 4 + d) * 16'h0F1D);
				play_move(2'(d));
				check_state("directed move");
			end
		end

		load_board(rows_to_board(16'h1234, 16'h0000, 16'h0000, 16'h0000));
		play_move(2'd0);
		check_state("still move left");
		read_reg(ADDR_STATUS, v);
		expect_word("last_moved after still move", {31'd0, v[2]}, 32'd0);
		play_move(2'd2);
		check_state("still move up");
		read_reg(ADDR_BOARD_LO, v);
		expect_word("board after still moves", v, 32'h0000_4321);
		read_reg(ADDR_SCORE, v);
		expect_word("score after still moves", v, 32'd0);

		load_board(rows_to_board(16'h1212, 16'h2121, 16'h1212, 16'h2121));
		check_state("stuck board");
		read_reg(ADDR_STATUS, v);
		expect_word("game over on stuck board", {31'd0, v[1]}, 32'd1);
		load_board(rows_to_board(16'h1212, 16'h2121, 16'h1212, 16'h2133));
		check_state("full board with a pair");
		read_reg(ADDR_STATUS, v);
		expect_word("game over with a pair", {31'd0, v[1]}, 32'd0);

		load_board(boards[0]);
		set_seed(16'h5A5A);
		start_move(2'd1, stall);
		start_move(2'd2, stall);
		expect_word("second MOVE held off while busy", {31'd0, stall > 0}, 32'd1);
		// Second move is still in the merge stage here
		read_reg(ADDR_STATUS, v);
		expect_word("busy during move", {31'd0, v[0]}, 32'd1);
		wait_idle();
		check_state("back-to-back moves");

		load_board(random_board());
		set_seed(16'($urandom) | 16'h0001);
		for (int n = 0; n < 200; n++) begin
			play_move(2'($urandom % 4));
			check_state("random move");
			if (m_over)
				load_board(random_board());
		end

		while (got_q.size() != 0)
			@(negedge clk);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD = 40
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

// File: game2048_core.sv
`default_nettype none
`include "game2048_params.svh"

module game2048_core (
	input  wire                    clk_sys,
	input  wire                    rst_n,
	input  wire [`GAME_AXI_AW-1:0] awaddr,
	input  wire                    awvalid,
	output logic                   awready,
	input  wire [31:0]             wdata,
	input  wire [3:0]              wstrb,
	input  wire                    wvalid,
	output logic                   wready,
	output logic [1:0]             bresp,
	output logic                   bvalid,
	input  wire                    bready,
	input  wire [`GAME_AXI_AW-1:0] araddr,
	input  wire                    arvalid,
	output logic                   arready,
	output logic [31:0]            rdata,
	output logic [1:0]             rresp,
	output logic                   rvalid,
	input  wire                    rready
);
	import game2048_pkg::*;

	board_t      board;
	score_t      score;
	dir_t        move_dir;
	dir_t        dir;
	logic        busy;
	logic        game_over;
	logic        last_moved;
	logic        move_start;
	logic        load_lo;
	logic        load_hi;
	logic        seed_load;
	logic [31:0] wdata_word;

	line_lane_if lane [`GAME_N] ();

	game2048_axil_regs u_regs (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.wvalid     (wvalid),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready),
		.busy       (busy),
		.board      (board),
		.score      (score),
		.game_over  (game_over),
		.last_moved (last_moved),
		.move_start (move_start),
		.move_dir   (move_dir),
		.load_lo    (load_lo),
		.load_hi    (load_hi),
		.seed_load  (seed_load),
		.wdata_word (wdata_word)
	);

	move_dispatch u_dispatch (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.move_start (move_start),
		.move_dir   (move_dir),
		.board      (board),
		.dir        (dir),
		.lane       (lane)
	);

	for (genvar i = 0; i < `GAME_N; i++) begin : g_merge
		line_merge u_merge (
			.clk_sys (clk_sys),
			.rst_n   (rst_n),
			.lane    (lane[i])
		);
	end

	board_update u_update (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.lane       (lane),
		.dir        (dir),
		.load_lo    (load_lo),
		.load_hi    (load_hi),
		.seed_load  (seed_load),
		.wdata_word (wdata_word),
		.board      (board),
		.score      (score),
		.game_over  (game_over),
		.last_moved (last_moved),
		.busy       (busy)
	);

endmodule

`default_nettype wire

// File: board_update.sv
`default_nettype none
`include "game2048_params.svh"

module board_update (
	input  wire                     clk_sys,
	input  wire                     rst_n,
	line_lane_if.drain              lane [`GAME_N],
	input  wire game2048_pkg::dir_t dir,
	input  wire                     load_lo,
	input  wire                     load_hi,
	input  wire                     seed_load,
	input  wire [31:0]              wdata_word,
	output game2048_pkg::board_t    board,
	output game2048_pkg::score_t    score,
	output logic                    game_over,
	output logic                    last_moved,
	output logic                    busy
);
	import game2048_pkg::*;

	localparam int CELLS = `GAME_N * `GAME_N;
	localparam int HALF = CELLS / 2;
	localparam int PW = $clog2(CELLS);
	localparam logic [15:0] LFSR_TAPS = 16'hB400;
	localparam logic [15:0] LFSR_INIT = 16'h0001;

	line_t             merged [`GAME_N];
	score_t            lane_gain [`GAME_N];
	logic [`GAME_N-1:0] lane_moved;
	logic [`GAME_N-1:0] lane_in_valid;
	logic [`GAME_N-1:0] lane_out_valid;

	logic        commit;
	logic        any_moved;
	score_t      gain_sum;
	logic [15:0] lfsr;
	logic [15:0] lfsr_next;
	board_t      slid;
	board_t      spawn_board;
	board_t      board_next;

	// No empty cell and no equal neighbor
	function automatic logic board_stuck(board_t b);
		logic stuck;
		stuck = 1'b1;
		for (int c = 0; c < CELLS; c++) begin
			if (b[c] == '0)
				stuck = 1'b0;
		end
		for (int r = 0; r < `GAME_N; r++) begin
			for (int c = 0; c < `GAME_N - 1; c++) begin
				if (b[r * `GAME_N + c] == b[r * `GAME_N + c + 1])
					stuck = 1'b0;
			end
		end
		for (int r = 0; r < `GAME_N - 1; r++) begin
			for (int c = 0; c < `GAME_N; c++) begin
				if (b[r * `GAME_N + c] == b[(r + 1) * `GAME_N + c])
					stuck = 1'b0;
			end
		end
		return stuck;
	endfunction

	for (genvar i = 0; i < `GAME_N; i++) begin : g_lane
		assign merged[i]         = lane[i].out_line;
		assign lane_gain[i]      = lane[i].out_gain;
		assign lane_moved[i]     = lane[i].out_moved;
		assign lane_in_valid[i]  = lane[i].in_valid;
		assign lane_out_valid[i] = lane[i].out_valid;
	end

	assign busy      = |lane_in_valid | |lane_out_valid;
	assign commit    = &lane_out_valid;
	assign any_moved = |lane_moved;
	assign lfsr_next = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? LFSR_TAPS : 16'h0000);

	// Inverse orientation back onto the grid
	always_comb begin
		slid = '0;
		gain_sum = '0;
		for (int i = 0; i < `GAME_N; i++) begin
			gain_sum = gain_sum + lane_gain[i];
			for (int k = 0; k < `GAME_N; k++)
				slid[cell_index(dir, i, k)] = merged[i][k];
		end
	end

	// First empty cell upward from the random start, wrapping
	always_comb begin : spawn_tile
		logic [PW-1:0] pos;
		logic found;
		spawn_board = slid;
		found = 1'b0;
		for (int j = 0; j < CELLS; j++) begin
			pos = lfsr_next[PW-1:0] + PW'(j);
			if (!found && slid[pos] == '0) begin
				spawn_board[pos] = lfsr_next[4] ? tile_t'(2) : tile_t'(1);
				found = 1'b1;
			end
		end
	end

	always_comb begin
		board_next = board;
		if (commit && any_moved)
			board_next = spawn_board;
		if (load_lo)
			board_next[HALF-1:0] = wdata_word;
		if (load_hi)
			board_next[CELLS-1:HALF] = wdata_word;
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			board      <= '0;
			score      <= '0;
			lfsr       <= LFSR_INIT;
			game_over  <= 1'b0;
			last_moved <= 1'b0;
		end else begin
			board <= board_next;
			if (commit || load_lo || load_hi)
				game_over <= board_stuck(board_next);
			if (load_lo)
				score <= '0;
			else if (commit)
				score <= score + gain_sum;
			if (commit)
				last_moved <= any_moved;
			if (seed_load)
				lfsr <= wdata_word[15:0];
			else if (commit && any_moved)
				lfsr <= lfsr_next;
		end
	end

endmodule

`default_nettype wire

// File: line_merge.sv
`default_nettype none
`include "game2048_params.svh"

module line_merge (
	input wire         clk_sys,
	input wire         rst_n,
	line_lane_if.merge lane
);
	import game2048_pkg::*;

	line_t  compact;
	line_t  merged;
	score_t gain;
	logic   changed;

	function automatic score_t line_mass(line_t l);
		score_t m;
		m = '0;
		for (int k = 0; k < `GAME_N; k++) begin
			if (l[k] != '0)
				m = m + (score_t'(1) << l[k]);
		end
		return m;
	endfunction

	// Slide nonzero tiles toward element 0
	always_comb begin : slide
		int n;
		n = 0;
		compact = '0;
		for (int i = 0; i < `GAME_N; i++) begin
			if (lane.in_line[i] != '0) begin
				compact[n] = lane.in_line[i];
				n++;
			end
		end
	end

	// Each pair merges once, scanning from element 0
	always_comb begin : merge_pairs
		tile_t [`GAME_N:0] ext;
		int n;
		logic skip;
		ext = {tile_t'(0), compact};
		n = 0;
		skip = 1'b0;
		merged = '0;
		gain = '0;
		for (int i = 0; i < `GAME_N; i++) begin
			if (skip) begin
				skip = 1'b0;
			end else if (ext[i] != '0) begin
				if (ext[i] == ext[i + 1] && ext[i] != '1) begin
					merged[n] = ext[i] + 1'b1;
					gain = gain + (score_t'(1) << (ext[i] + 1'b1));
					skip = 1'b1;
				end else begin
					merged[n] = ext[i];
				end
				n++;
			end
		end
	end

	assign changed = merged != lane.in_line;

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			lane.out_valid <= 1'b0;
		else
			lane.out_valid <= lane.in_valid;
	end

	always_ff @(posedge clk_sys) begin
		if (lane.in_valid) begin
			lane.out_line  <= merged;
			lane.out_gain  <= gain;
			lane.out_moved <= changed;
		end
	end

	// Total tile value is conserved, so no merge wrapped past exponent 15
	assert property (@(posedge clk_sys) disable iff (!rst_n)
		lane.in_valid |=> line_mass(lane.out_line) == $past(line_mass(lane.in_line)));

endmodule

`default_nettype wire

// File: move_dispatch.sv
`default_nettype none
`include "game2048_params.svh"

module move_dispatch (
	input  wire                       clk_sys,
	input  wire                       rst_n,
	input  wire                       move_start,
	input  wire game2048_pkg::dir_t   move_dir,
	input  wire game2048_pkg::board_t board,
	output game2048_pkg::dir_t        dir,
	line_lane_if.feed                 lane [`GAME_N]
);
	import game2048_pkg::*;

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			dir <= DIR_LEFT;
		else if (move_start)
			dir <= move_dir;
	end

	// One oriented line per merger
	for (genvar i = 0; i < `GAME_N; i++) begin : g_lane
		always_ff @(posedge clk_sys) begin
			if (!rst_n)
				lane[i].in_valid <= 1'b0;
			else
				lane[i].in_valid <= move_start;
		end

		always_ff @(posedge clk_sys) begin
			if (move_start) begin
				for (int k = 0; k < `GAME_N; k++)
					lane[i].in_line[k] <= board[cell_index(move_dir, i, k)];
			end
		end
	end

	// Next move only after the merge and commit stages have drained
	assert property (@(posedge clk_sys) disable iff (!rst_n)
		move_start |=> !move_start [*3]);

endmodule

`default_nettype wire

// File: game2048_axil_regs.sv
`default_nettype none
`include "game2048_params.svh"

module game2048_axil_regs (
	input  wire                          clk_sys,
	input  wire                          rst_n,
	input  wire [`GAME_AXI_AW-1:0]       awaddr,
	input  wire                          awvalid,
	output logic                         awready,
	input  wire [31:0]                   wdata,
	input  wire [3:0]                    wstrb,
	input  wire                          wvalid,
	output logic                         wready,
	output logic [1:0]                   bresp,
	output logic                         bvalid,
	input  wire                          bready,
	input  wire [`GAME_AXI_AW-1:0]       araddr,
	input  wire                          arvalid,
	output logic                         arready,
	output logic [31:0]                  rdata,
	output logic [1:0]                   rresp,
	output logic                         rvalid,
	input  wire                          rready,
	input  wire                          busy,
	input  wire game2048_pkg::board_t    board,
	input  wire game2048_pkg::score_t    score,
	input  wire                          game_over,
	input  wire                          last_moved,
	output logic                         move_start,
	output game2048_pkg::dir_t           move_dir,
	output logic                         load_lo,
	output logic                         load_hi,
	output logic                         seed_load,
	output logic [31:0]                  wdata_word
);
	import game2048_pkg::*;

	localparam int CELLS = `GAME_N * `GAME_N;
	localparam int HALF = CELLS / 2;

	localparam logic [`GAME_AXI_AW-3:0] REG_MOVE     = 'd0;
	localparam logic [`GAME_AXI_AW-3:0] REG_STATUS   = 'd1;
	localparam logic [`GAME_AXI_AW-3:0] REG_SCORE    = 'd2;
	localparam logic [`GAME_AXI_AW-3:0] REG_SEED     = 'd3;
	localparam logic [`GAME_AXI_AW-3:0] REG_BOARD_LO = 'd4;
	localparam logic [`GAME_AXI_AW-3:0] REG_BOARD_HI = 'd5;

	logic                    wr_hs;
	logic                    wr_en;
	logic [`GAME_AXI_AW-3:0] wr_idx;
	logic                    rd_hs;
	logic [31:0]             rd_word;

	// Address and data go together, one response outstanding, none while a move runs
	assign awready = awvalid & wvalid & ~bvalid & ~busy & ~move_start;
	assign wready  = awready;
	assign wr_hs   = awvalid & wvalid & awready;
	assign wr_en   = |wstrb;
	assign wr_idx  = awaddr[`GAME_AXI_AW-1:2];
	assign bresp   = 2'b00;

	assign arready = ~rvalid;
	assign rd_hs   = arvalid & arready;
	assign rresp   = 2'b00;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			bvalid     <= 1'b0;
			move_start <= 1'b0;
			load_lo    <= 1'b0;
			load_hi    <= 1'b0;
			seed_load  <= 1'b0;
		end else begin
			move_start <= wr_hs && wr_en && wr_idx == REG_MOVE;
			load_lo    <= wr_hs && wr_en && wr_idx == REG_BOARD_LO;
			load_hi    <= wr_hs && wr_en && wr_idx == REG_BOARD_HI;
			seed_load  <= wr_hs && wr_en && wr_idx == REG_SEED;
			if (wr_hs)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_hs) begin
			wdata_word <= wdata;
			move_dir   <= dir_t'(wdata[1:0]);
		end
	end

	always_comb begin
		case (araddr[`GAME_AXI_AW-1:2])
			REG_STATUS:   rd_word = {29'd0, last_moved, game_over, busy | move_start};
			REG_SCORE:    rd_word = score;
			REG_BOARD_LO: rd_word = board[HALF-1:0];
			REG_BOARD_HI: rd_word = board[CELLS-1:HALF];
			default:      rd_word = '0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			rvalid <= 1'b0;
		else if (rd_hs)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (rd_hs)
			rdata <= rd_word;
	end

	// Write response held until taken
	assert property (@(posedge clk_sys) disable iff (!rst_n) bvalid && !bready |=> bvalid);

endmodule

`default_nettype wire

// File: line_lane_if.sv
`default_nettype none

interface line_lane_if;
	import game2048_pkg::*;

	logic   in_valid;
	line_t  in_line;
	logic   out_valid;
	line_t  out_line;
	score_t out_gain;
	logic   out_moved;

	modport feed (output in_valid, output in_line);

	modport merge (
		input  in_valid,
		input  in_line,
		output out_valid,
		output out_line,
		output out_gain,
		output out_moved
	);

	// in_valid too, so the updater sees a move in its first stage
	modport drain (input in_valid, input out_valid, input out_line, input out_gain, input out_moved);

endinterface

`default_nettype wire

// File: game2048_pkg.sv
`default_nettype none
`include "game2048_params.svh"

package game2048_pkg;

	typedef logic [`GAME_TILE_W-1:0] tile_t;

	// Element 0 is the end tiles slide toward
	typedef tile_t [`GAME_N-1:0] line_t;

	// Cell r*N+c, row 0 on top
	typedef tile_t [`GAME_N*`GAME_N-1:0] board_t;

	typedef enum logic [1:0] {
		DIR_LEFT  = 2'd0,
		DIR_RIGHT = 2'd1,
		DIR_UP    = 2'd2,
		DIR_DOWN  = 2'd3
	} dir_t;

	typedef logic [31:0] score_t;

	// Board cell holding element k of oriented line i
	function automatic int unsigned cell_index(dir_t d, int unsigned i, int unsigned k);
		case (d)
			DIR_LEFT:  return i * `GAME_N + k;
			DIR_RIGHT: return i * `GAME_N + (`GAME_N - 1 - k);
			DIR_UP:    return k * `GAME_N + i;
			default:   return (`GAME_N - 1 - k) * `GAME_N + i;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: game2048_params.svh
`ifndef GAME2048_PARAMS_SVH
`define GAME2048_PARAMS_SVH

// Board side in cells
`define GAME_N 4

// Bits per tile exponent
`define GAME_TILE_W 4

// Byte address width of the register slave
`define GAME_AXI_AW 5

`endif
